// File: dv/icache_chk.sv
// Bound assertions on lookup response timing, fill probe timing and memory request pulses
`timescale 1ns/1ps

module icache_chk (
	input logic rclk,
	input logic arst_n,
	// Strobe and the signal that must trail it by one cycle
	input logic lead,
	input logic follow,
	// External memory request and the enable that gates it
	input logic pulse,
	input logic gate
);

	// Failed assertions, summed by the testbench
	int fails = 0;

	// Follower is the strobe delayed by exactly one cycle
	a_follow_one_cycle: assert property (@(posedge rclk) disable iff (!arst_n)
		follow == $past(lead))
	else begin
		$error("response or probe state did not trail its strobe by one cycle");
		fails++;
	end

	// Memory request never lasts longer than one cycle
	a_req_one_wide: assert property (@(posedge rclk) disable iff (!arst_n)
		pulse |=> !pulse)
	else begin
		$error("memory request held for more than one cycle");
		fails++;
	end

	// No request goes out with the cache disabled
	a_req_needs_enable: assert property (@(posedge rclk) disable iff (!arst_n)
		pulse |-> gate)
	else begin
		$error("memory request issued while the cache is disabled");
		fails++;
	end

endmodule

// Top level: lookup response follows fetch strobe
bind icache_top icache_chk top_chk_i (
	.rclk   (rclk),
	.arst_n (arst_n),
	.lead   (fetch_req),
	.follow (fetch_rsp.valid),
	.pulse  (mem_req),
	.gate   (enable)
);

// Fill FSM: PROBE state follows the probe strobe
bind icache_fill icache_chk fill_chk_i (
	.rclk   (rclk),
	.arst_n (arst_n),
	.lead   (probe_strobe),
	.follow (state_q == icache_pkg::PROBE),
	.pulse  (mem_req),
	.gate   (enable)
);

// File: dv/icache_tb.sv
// Instruction cache testbench with clock, reset, random stimulus, memory responder, model, checks
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_tb;
	import icache_pkg::*;

	// Memory contents are byte address XOR this pattern
	localparam word_t PATTERN = 32'hc3a5_0f96;
	// Number of test steps, each allowed 200 cycles by the watchdog
	localparam int STEPS = 100;

	logic       rclk = 1'b0;
	logic       arst_n;
	logic       fetch_req;
	addr_t      fetch_addr;
	fetch_rsp_t fetch_rsp;
	logic       mem_req;
	addr_t      mem_addr;
	mem_rsp_t   mem_rsp;
	logic       reg_wr;
	logic       reg_rd;
	reg_addr_t  reg_addr;
	word_t      reg_wdata;
	word_t      reg_rdata;

	// Stimulus and responder draw from separate streams
	int seed      = 32'h4971d3b9;
	int resp_seed = 32'h4971d3b9;

	// ========================================
	// Reference model state
	// ========================================
	tag_t         m_tag [256];
	logic [255:0] m_valid = '0;
	logic [255:0] m_err = '0;
	logic         m_enable = 1'b0;
	int           m_hits = 0;
	int           m_misses = 0;
	logic         m_last_hit;

	// Bus monitor
	int    mem_req_count = 0;
	int    commit_count = 0;
	addr_t last_mem_addr;
	addr_t mon_line;
	int    mon_beats = 0;
	logic  mon_err = 1'b0;
	logic  commit_pend = 1'b0;

	// Memory responder
	logic  resp_active = 1'b0;
	addr_t resp_line;
	int    resp_beat;
	int    resp_gap;

	int   checks = 0;
	int   errors = 0;
	logic last_hit;
	logic last_err;

	icache_top dut_i (
		.rclk       (rclk),
		.arst_n     (arst_n),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.fetch_rsp  (fetch_rsp),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_rsp    (mem_rsp),
		.reg_wr     (reg_wr),
		.reg_rd     (reg_rd),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata)
	);

	always #50 rclk = ~rclk;

	// Address fields: tag 31..13, index 12..5
	function automatic index_t idx_of(addr_t a);
		return a[12:5];
	endfunction

	function automatic tag_t tag_of(addr_t a);
		return a[31:13];
	endfunction

	function automatic word_t pattern_word(addr_t a);
		return {a[31:2], 2'b00} ^ PATTERN;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ========================================
	// Monitor and memory responder
	// ========================================

	// Table updates at clock edges, commit one cycle after the eighth ack
	always @(posedge rclk) begin
		if (arst_n) begin
			if (commit_pend) begin
				m_valid[idx_of(mon_line)] = 1'b1;
				m_tag[idx_of(mon_line)]   = tag_of(mon_line);
				m_err[idx_of(mon_line)]   = mon_err;
				commit_pend = 1'b0;
				commit_count++;
			end
			if (mem_req) begin
				// Line is freed while it refills
				mem_req_count++;
				last_mem_addr = mem_addr;
				mon_line = mem_addr;
				m_valid[idx_of(mem_addr)] = 1'b0;
				mon_beats = 0;
				mon_err = 1'b0;
			end
			if (mem_rsp.ack) begin
				mon_beats++;
				mon_err = mon_err | mem_rsp.err;
				if (mon_beats == 8)
					commit_pend = 1'b1;
			end
		end
	end

	// Eight words per request with gaps of 0 to 3 cycles
	// Lines at an index that is a multiple of 17 flag an error on beat 3
	always @(negedge rclk) begin
		mem_rsp = '0;
		if (!arst_n) begin
			resp_active = 1'b0;
		end else if (resp_active) begin
			if (resp_gap > 0) begin
				resp_gap--;
			end else begin
				mem_rsp.ack  = 1'b1;
				mem_rsp.word = pattern_word(resp_line + 4 * resp_beat);
				mem_rsp.err  = (idx_of(resp_line) % 17 == 0) && (resp_beat == 3);
				resp_beat++;
				resp_gap = {$random(resp_seed)} % 4;
				if (resp_beat == 8)
					resp_active = 1'b0;
			end
		end else if (mem_req) begin
			resp_active = 1'b1;
			resp_line   = mem_addr;
			resp_beat   = 0;
			resp_gap    = {$random(resp_seed)} % 4;
		end
	end

	// ========================================
	// Stimulus tasks
	// ========================================
	task automatic idle(input int n);
		repeat (n) @(negedge rclk);
	endtask

	// Expectation comes from the model as the strobe goes out
	task automatic send_fetch(input addr_t a, output logic eh, output logic ee);
		eh = m_valid[idx_of(a)] && (m_tag[idx_of(a)] == tag_of(a));
		ee = m_err[idx_of(a)];
		fetch_req  = 1'b1;
		fetch_addr = a;
	endtask

	task automatic expect_rsp(input addr_t a, input logic eh, input logic ee);
		check(fetch_rsp.valid, 1'b1, "response valid");
		check(fetch_rsp.hit, eh, $sformatf("hit for %h", a));
		if (eh) begin
			check(fetch_rsp.err, ee, $sformatf("err for %h", a));
			check(fetch_rsp.word, pattern_word(a), $sformatf("word for %h", a));
			m_hits++;
		end else begin
			m_misses++;
		end
		m_last_hit = eh;
		last_hit   = fetch_rsp.hit;
		last_err   = fetch_rsp.err;
	endtask

	task automatic fetch(input addr_t a);
		logic eh;
		logic ee;
		send_fetch(a, eh, ee);
		@(negedge rclk);
		fetch_req = 1'b0;
		expect_rsp(a, eh, ee);
	endtask

	// Back to back strobes
	task automatic fetch_pair(input addr_t a, input addr_t b);
		logic eh_a;
		logic ee_a;
		logic eh_b;
		logic ee_b;
		send_fetch(a, eh_a, ee_a);
		@(negedge rclk);
		send_fetch(b, eh_b, ee_b);
		expect_rsp(a, eh_a, ee_a);
		@(negedge rclk);
		fetch_req = 1'b0;
		expect_rsp(b, eh_b, ee_b);
	endtask

	task automatic wait_commit(input int n);
		while (commit_count < n)
			@(negedge rclk);
	endtask

	// Fetch, and on an expected miss with the cache on, wait out the refill
	task automatic lookup(input addr_t a);
		int reqs;
		int fills;
		reqs  = mem_req_count;
		fills = commit_count;
		fetch(a);
		if (!m_last_hit && m_enable) begin
			wait_commit(fills + 1);
			check(mem_req_count, reqs + 1, "one request per miss");
			check(last_mem_addr, {a[31:5], 5'b0}, "request line address");
		end
	endtask

	task automatic reg_write(input reg_addr_t a, input word_t d);
		reg_wr    = 1'b1;
		reg_addr  = a;
		reg_wdata = d;
		@(negedge rclk);
		reg_wr = 1'b0;
	endtask

	task automatic reg_read(input reg_addr_t a, output word_t d);
		reg_rd   = 1'b1;
		reg_addr = a;
		@(negedge rclk);
		reg_rd = 1'b0;
		d = reg_rdata;
	endtask

	task automatic write_ctrl(input logic en, input logic inv);
		word_t v;
		reg_write(reg_addr_t'(`ICACHE_REG_CTRL), {30'b0, inv, en});
		m_enable = en;
		if (inv) begin
			// Valid bits clear one cycle after the write
			idle(1);
			m_valid = '0;
			m_err   = '0;
		end
		reg_read(reg_addr_t'(`ICACHE_REG_CTRL), v);
		check(v, {31'b0, en}, "CTRL readback");
	endtask

	// One idle cycle lets the last hit or miss pulse land
	task automatic check_counters();
		word_t v;
		idle(1);
		reg_read(reg_addr_t'(`ICACHE_REG_HITS), v);
		check(v, m_hits, "HITS counter");
		reg_read(reg_addr_t'(`ICACHE_REG_MISSES), v);
		check(v, m_misses, "MISSES counter");
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		addr_t a;
		addr_t b;
		addr_t resident [$];
		int    reqs;
		int    fills;
		int    assert_fails;
		fetch_req  = 1'b0;
		fetch_addr = '0;
		reg_wr     = 1'b0;
		reg_rd     = 1'b0;
		reg_addr   = '0;
		reg_wdata  = '0;
		mem_rsp    = '0;
		arst_n     = 1'b0;
		repeat (2) @(posedge rclk);
		@(negedge rclk);
		arst_n = 1'b1;
		idle(1);

		// Disabled cache, every fetch misses and memory stays quiet
		for (int i = 0; i < 16; i++)
			fetch($random(seed));
		idle(4);
		check(mem_req_count, 0, "requests while disabled");
		check_counters();

		// Refill, then other words of the same line hit
		write_ctrl(1'b1, 1'b0);
		for (int i = 0; i < 8; i++) begin
			a = $random(seed);
			lookup(a);
			resident.push_back(a);
			for (int j = 0; j < 3; j++) begin
				b = {a[31:5], 3'($random(seed)), 2'b00};
				lookup(b);
				check(last_hit, 1'b1, "hit in filled line");
			end
		end

		// Same index, different tags
		for (int i = 0; i < 4; i++) begin
			a = $random(seed);
			b = a ^ {19'($random(seed)) | 19'd1, 13'd0};
			lookup(a);
			lookup(b);
			lookup(a);
			check(last_hit, 1'b0, "evicted line refetch");
			lookup(b);
			check(last_hit, 1'b0, "evicted line refetch");
		end

		// Erroring index
		a = {19'($random(seed)), 8'(17 * ({$random(seed)} % 16)), 3'($random(seed)), 2'b00};
		lookup(a);
		lookup(a);
		check(last_hit, 1'b1, "hit on erroring line");
		check(last_err, 1'b1, "err on erroring line");
		resident.push_back(a);

		// Invalidate with fills off so resident lines stay missing
		check_counters();
		write_ctrl(1'b0, 1'b1);
		foreach (resident[i]) begin
			fetch(resident[i]);
			check(last_hit, 1'b0, "resident line after invalidate");
		end
		check_counters();
		reg_write(reg_addr_t'(`ICACHE_REG_HITS), 32'hffff_ffff);
		reg_write(reg_addr_t'(`ICACHE_REG_MISSES), $random(seed));
		m_hits   = 0;
		m_misses = 0;
		check_counters();

		// Two misses to one line during one fill
		write_ctrl(1'b1, 1'b0);
		a     = $random(seed);
		reqs  = mem_req_count;
		fills = commit_count;
		fetch_pair(a, {a[31:5], 3'($random(seed)), 2'b00});
		wait_commit(fills + 1);
		idle(8);
		check(mem_req_count, reqs + 1, "single request for two misses");

		// Lookup on the commit cycle misses, probe then drops it
		a     = $random(seed);
		reqs  = mem_req_count;
		fetch(a);
		while (!commit_pend)
			@(negedge rclk);
		fetch(a);
		check(last_hit, 1'b0, "lookup on commit cycle");
		idle(8);
		check(mem_req_count, reqs + 1, "resident line dropped at probe");
		lookup(a);
		check(last_hit, 1'b1, "line after dropped refill");
		check_counters();

		assert_fails = dut_i.top_chk_i.fails + dut_i.fill_i.fill_chk_i.fails;
		$display("Checks: %0d, check errors: %0d, assertion errors: %0d",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Watchdog, 200 cycles of 100 ns for each test step
	initial begin
		#(STEPS * 200 * 100);
		$display("Watchdog expired: the test sequence did not complete in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: hdl/icache_ctrl_regs.sv
// Instruction cache control register, invalidate command and hit and miss counters
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_ctrl_regs (
	input  logic                  rclk,
	input  logic                  arst_n,
	input  logic                  reg_wr,
	input  logic                  reg_rd,
	input  icache_pkg::reg_addr_t reg_addr,
	input  icache_pkg::word_t     reg_wdata,
	output icache_pkg::word_t     reg_rdata,
	input  logic                  hit_pulse,
	input  logic                  miss_pulse,
	output logic                  enable,
	output logic                  invalidate
);
	import icache_pkg::*;

	count_t hits_q;
	count_t misses_q;
	logic   ctrl_wr;
	logic   hits_wr;
	logic   misses_wr;

	// Write decode
	assign ctrl_wr   = reg_wr && (reg_addr == reg_addr_t'(`ICACHE_REG_CTRL));
	assign hits_wr   = reg_wr && (reg_addr == reg_addr_t'(`ICACHE_REG_HITS));
	assign misses_wr = reg_wr && (reg_addr == reg_addr_t'(`ICACHE_REG_MISSES));

	// ========================================
	// Control and counters
	// ========================================
	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n) begin
			enable     <= 1'b0;
			invalidate <= 1'b0;
			hits_q     <= '0;
			misses_q   <= '0;
		end else begin
			// Invalidate lasts one cycle
			invalidate <= ctrl_wr && reg_wdata[1];
			if (ctrl_wr)
				enable <= reg_wdata[0];
			// A write clears the counter, even with a pulse on the same cycle
			if (hits_wr)
				hits_q <= '0;
			else if (hit_pulse)
				hits_q <= hits_q + 1'b1;
			if (misses_wr)
				misses_q <= '0;
			else if (miss_pulse)
				misses_q <= misses_q + 1'b1;
		end
	end

	// Read data one cycle after the strobe
	// invalidate bit always reads back as zero
	always_ff @(posedge rclk) begin
		if (reg_rd) begin
			case (reg_addr)
				reg_addr_t'(`ICACHE_REG_CTRL):   reg_rdata <= {31'b0, enable};
				reg_addr_t'(`ICACHE_REG_HITS):   reg_rdata <= hits_q;
				reg_addr_t'(`ICACHE_REG_MISSES): reg_rdata <= misses_q;
				default:                         reg_rdata <= '0;
			endcase
		end
	end

endmodule

// File: hdl/icache_datamem.sv
// Instruction cache line word storage with fill write port and fetch read port
`timescale 1ns/1ps

module icache_datamem (
	input  logic                  rclk,
	input  logic                  rce,
	input  icache_pkg::addr_t     ra,
	input  logic                  dwr,
	input  icache_pkg::index_t    dwr_index,
	input  icache_pkg::word_sel_t dwr_sel,
	input  icache_pkg::word_t     dwr_word,
	output icache_pkg::word_t     rword
);
	import icache_pkg::*;

	// ========================================
	// Storage
	// ========================================

	// Flat word array addressed by line index and word select
	word_t line_mem [LINES*WORDS];

	logic [INDEX_W+SEL_W-1:0] wr_slot;
	logic [INDEX_W+SEL_W-1:0] rd_slot;

	assign wr_slot = {dwr_index, dwr_sel};
	assign rd_slot = {addr_index(ra), addr_sel(ra)};

	// One word per memory beat during a fill
	always_ff @(posedge rclk) begin
		if (dwr)
			line_mem[wr_slot] <= dwr_word;
	end

	// ========================================
	// Fetch read
	// ========================================

	// Same strobe as the tag lookup
	// Word lands on the response cycle next to hit
	always_ff @(posedge rclk) begin
		if (rce)
			rword <= line_mem[rd_slot];
	end

endmodule

// File: hdl/icache_fill.sv
// Instruction cache line fill FSM with miss capture, residency probe and tag commit
`timescale 1ns/1ps

module icache_fill (
	input  logic                  rclk,
	input  logic                  arst_n,
	input  logic                  enable,
	input  logic                  miss,
	input  icache_pkg::addr_t     miss_addr,
	input  logic                  whit,
	output logic                  probe_strobe,
	output icache_pkg::addr_t     probe_addr,
	output logic                  mem_req,
	output icache_pkg::addr_t     mem_addr,
	input  icache_pkg::mem_rsp_t  mem_rsp,
	output logic                  dwr,
	output icache_pkg::index_t    dwr_index,
	output icache_pkg::word_sel_t dwr_sel,
	output icache_pkg::word_t     dwr_word,
	output icache_pkg::tag_wr_t   tag_wr
);
	import icache_pkg::*;

	fill_state_t state_q;
	fill_state_t state_d;

	// Line being filled
	addr_t     line_q;
	// Next word expected from memory
	word_sel_t beat_q;
	// OR of all beat errors so far
	logic      err_acc_q;
	logic      capture;
	logic      last_beat;

	// Only a miss seen while idle starts a fill
	assign capture   = (state_q == IDLE) && miss && enable;
	assign last_beat = (beat_q == '1);

	// ========================================
	// Next state
	// ========================================
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:
				if (capture)
					state_d = PROBE;
			PROBE:
				// Resident already, or fills switched off meanwhile
				if (whit || !enable)
					state_d = IDLE;
				else
					state_d = REQ;
			REQ:
				state_d = enable ? BEAT : IDLE;
			BEAT:
				// Memory may stall here between acks
				if (mem_rsp.ack && last_beat)
					state_d = COMMIT;
			COMMIT:
				state_d = IDLE;
			default:
				state_d = IDLE;
		endcase
	end

	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	// Captured line address
	always_ff @(posedge rclk) begin
		if (capture)
			line_q <= line_base(miss_addr);
	end

	// Beat counter and error accumulation
	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n) begin
			beat_q    <= '0;
			err_acc_q <= 1'b0;
		end else if (state_q == REQ) begin
			beat_q    <= '0;
			err_acc_q <= 1'b0;
		end else if (state_q == BEAT && mem_rsp.ack) begin
			beat_q    <= beat_q + 1'b1;
			err_acc_q <= err_acc_q | mem_rsp.err;
		end
	end

	// ========================================
	// Outputs
	// ========================================

	// Probe goes out with the capture so whit is ready in PROBE
	assign probe_strobe = capture;
	assign probe_addr   = miss_addr;

	// Single request pulse, suppressed if enable dropped
	assign mem_req  = (state_q == REQ) && enable;
	assign mem_addr = line_q;

	// Each ack writes its word straight into the line store
	assign dwr       = (state_q == BEAT) && mem_rsp.ack;
	assign dwr_index = addr_index(line_q);
	assign dwr_sel   = beat_q;
	assign dwr_word  = mem_rsp.word;

	// Tag commit the cycle after the last ack
	assign tag_wr.strobe = (state_q == COMMIT);
	assign tag_wr.addr   = line_q;
	assign tag_wr.err    = err_acc_q;

endmodule

// File: hdl/icache_pkg.sv
// Instruction cache types, fill FSM states, bundles and address field helpers
`include "icache_cfg.svh"

package icache_pkg;

	// Field widths derived from the geometry macros
	localparam int ADDR_W   = `ICACHE_ADDR_W;
	localparam int LINES    = `ICACHE_LINES;
	localparam int WORDS    = `ICACHE_WORDS_PER_LINE;
	localparam int OFFSET_W = `ICACHE_OFFSET_W;
	localparam int INDEX_W  = $clog2(LINES);
	localparam int SEL_W    = $clog2(WORDS);
	localparam int TAG_W    = ADDR_W - OFFSET_W - INDEX_W;

	typedef logic [ADDR_W-1:0]  addr_t;
	typedef logic [TAG_W-1:0]   tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [SEL_W-1:0]   word_sel_t;
	typedef logic [31:0]        word_t;
	typedef logic [31:0]        count_t;
	typedef logic [1:0]         reg_addr_t;

	// Line fill controller states
	typedef enum logic [2:0] {
		IDLE,
		PROBE,
		REQ,
		BEAT,
		COMMIT
	} fill_state_t;

	// Lookup answer to the fetch stage
	typedef struct packed {
		logic  valid;
		logic  hit;
		logic  err;
		word_t word;
	} fetch_rsp_t;

	// One beat from external memory
	typedef struct packed {
		logic  ack;
		logic  err;
		word_t word;
	} mem_rsp_t;

	// Tag commit from the fill controller
	typedef struct packed {
		logic  strobe;
		addr_t addr;
		logic  err;
	} tag_wr_t;

	// Address field extraction
	function automatic tag_t addr_tag(addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[OFFSET_W +: INDEX_W];
	endfunction

	function automatic word_sel_t addr_sel(addr_t a);
		return a[2 +: SEL_W];
	endfunction

	// Line base address, byte offset forced to zero
	function automatic addr_t line_base(addr_t a);
		return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
	endfunction

endpackage

// File: hdl/icache_tagmem.sv
// Instruction cache tag array with valid and error bits, fetch read port and fill probe
`timescale 1ns/1ps

module icache_tagmem (
	input  logic                rclk,
	input  logic                arst_n,
	input  logic                invalidate,
	input  logic                rce,
	input  icache_pkg::addr_t   ra,
	input  logic                probe_strobe,
	input  icache_pkg::addr_t   probe_addr,
	input  icache_pkg::tag_wr_t tag_wr,
	output logic                rhit,
	output logic                whit,
	output logic                err
);
	import icache_pkg::*;

	// Stored tags, no reset since valid bits qualify them
	tag_t tag_mem [LINES];
	logic [LINES-1:0] valid_q;
	logic [LINES-1:0] err_q;

	// Fetch side registered read
	tag_t rd_addr_tag_q;
	tag_t rd_line_tag_q;
	logic rd_valid_q;
	logic rd_err_q;

	// Probe side
	addr_t  probe_addr_q;
	logic   probe_q;
	index_t probe_index;
	index_t wr_index;

	assign probe_index = addr_index(probe_addr_q);
	assign wr_index    = addr_index(tag_wr.addr);

	// Tag write on commit
	always_ff @(posedge rclk) begin
		if (tag_wr.strobe)
			tag_mem[wr_index] <= addr_tag(tag_wr.addr);
	end

	// Valid and error bits
	// A probe that misses frees the line since its words are about to be overwritten
	// Commit comes last so a fill that spans an invalidate still lands
	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
			err_q   <= '0;
		end else begin
			if (probe_q && !whit)
				valid_q[probe_index] <= 1'b0;
			if (invalidate) begin
				valid_q <= '0;
				err_q   <= '0;
			end
			if (tag_wr.strobe) begin
				valid_q[wr_index] <= 1'b1;
				err_q[wr_index]   <= tag_wr.err;
			end
		end
	end

	// Fetch lookup
	// State is sampled at the strobe so a same-cycle commit is not seen
	always_ff @(posedge rclk) begin
		if (rce) begin
			rd_addr_tag_q <= addr_tag(ra);
			rd_line_tag_q <= tag_mem[addr_index(ra)];
			rd_valid_q    <= valid_q[addr_index(ra)];
			rd_err_q      <= err_q[addr_index(ra)];
		end
	end

	assign rhit = rd_valid_q && (rd_line_tag_q == rd_addr_tag_q);
	assign err  = rd_err_q;

	// Residency probe, compared against live state on the following cycle
	always_ff @(posedge rclk) begin
		if (probe_strobe)
			probe_addr_q <= probe_addr;
	end

	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n)
			probe_q <= 1'b0;
		else
			probe_q <= probe_strobe;
	end

	assign whit = valid_q[probe_index] && (tag_mem[probe_index] == addr_tag(probe_addr_q));

endmodule

// File: hdl/icache_top.sv
// Instruction cache subsystem top with tag store, line store, fill FSM and registers
`timescale 1ns/1ps

module icache_top (
	input  logic                   rclk,
	input  logic                   arst_n,
	// Fetch stage
	input  logic                   fetch_req,
	input  icache_pkg::addr_t      fetch_addr,
	output icache_pkg::fetch_rsp_t fetch_rsp,
	// External memory
	output logic                   mem_req,
	output icache_pkg::addr_t      mem_addr,
	input  icache_pkg::mem_rsp_t   mem_rsp,
	// Register port
	input  logic                   reg_wr,
	input  logic                   reg_rd,
	input  icache_pkg::reg_addr_t  reg_addr,
	input  icache_pkg::word_t      reg_wdata,
	output icache_pkg::word_t      reg_rdata
);
	import icache_pkg::*;

	// ========================================
	// Internal nets
	// ========================================

	// Lookup result
	logic      rhit;
	logic      rd_err;
	word_t     rword;
	logic      rsp_valid_q;
	addr_t     rsp_addr_q;
	logic      hit_pulse;
	logic      miss_pulse;

	// Fill side
	logic      whit;
	logic      probe_strobe;
	addr_t     probe_addr;
	logic      dwr;
	index_t    dwr_index;
	word_sel_t dwr_sel;
	word_t     dwr_word;
	tag_wr_t   tag_wr;

	// Control
	logic      enable;
	logic      invalidate;

	// Response valid is the strobe delayed by one cycle
	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n)
			rsp_valid_q <= 1'b0;
		else
			rsp_valid_q <= fetch_req;
	end

	// Address of the lookup in flight, handed to the fill FSM on a miss
	always_ff @(posedge rclk) begin
		if (fetch_req)
			rsp_addr_q <= fetch_addr;
	end

	assign fetch_rsp.valid = rsp_valid_q;
	assign fetch_rsp.hit   = rhit;
	assign fetch_rsp.err   = rd_err;
	assign fetch_rsp.word  = rword;

	assign hit_pulse  = rsp_valid_q && rhit;
	assign miss_pulse = rsp_valid_q && !rhit;

	// ========================================
	// Instances
	// ========================================
	icache_tagmem tagmem_i (
		.rclk         (rclk),
		.arst_n       (arst_n),
		.invalidate   (invalidate),
		.rce          (fetch_req),
		.ra           (fetch_addr),
		.probe_strobe (probe_strobe),
		.probe_addr   (probe_addr),
		.tag_wr       (tag_wr),
		.rhit         (rhit),
		.whit         (whit),
		.err          (rd_err)
	);

	icache_datamem datamem_i (
		.rclk      (rclk),
		.rce       (fetch_req),
		.ra        (fetch_addr),
		.dwr       (dwr),
		.dwr_index (dwr_index),
		.dwr_sel   (dwr_sel),
		.dwr_word  (dwr_word),
		.rword     (rword)
	);

	icache_fill fill_i (
		.rclk         (rclk),
		.arst_n       (arst_n),
		.enable       (enable),
		.miss         (miss_pulse),
		.miss_addr    (rsp_addr_q),
		.whit         (whit),
		.probe_strobe (probe_strobe),
		.probe_addr   (probe_addr),
		.mem_req      (mem_req),
		.mem_addr     (mem_addr),
		.mem_rsp      (mem_rsp),
		.dwr          (dwr),
		.dwr_index    (dwr_index),
		.dwr_sel      (dwr_sel),
		.dwr_word     (dwr_word),
		.tag_wr       (tag_wr)
	);

	icache_ctrl_regs regs_i (
		.rclk       (rclk),
		.arst_n     (arst_n),
		.reg_wr     (reg_wr),
		.reg_rd     (reg_rd),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata),
		.hit_pulse  (hit_pulse),
		.miss_pulse (miss_pulse),
		.enable     (enable),
		.invalidate (invalidate)
	);

endmodule

// File: include/icache_cfg.svh
// Instruction cache geometry and register offset macros
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// ========================================
// Cache geometry
// ========================================

// Fetch and line address width in bits
`define ICACHE_ADDR_W 32

// Direct mapped, one line per index
`define ICACHE_LINES 256

// Eight 32-bit words make one 32-byte line
`define ICACHE_WORDS_PER_LINE 8

// Byte offset bits within a line
`define ICACHE_OFFSET_W 5

// ========================================
// Register port offsets
// ========================================

// Enable in bit 0, invalidate-all command in bit 1
`define ICACHE_REG_CTRL 0
// Hit counter, cleared by any write
`define ICACHE_REG_HITS 1
// Miss counter, cleared by any write
`define ICACHE_REG_MISSES 2

`endif

// File: project.f
+incdir+include
hdl/icache_pkg.sv
hdl/icache_tagmem.sv
hdl/icache_datamem.sv
hdl/icache_fill.sv
hdl/icache_ctrl_regs.sv
hdl/icache_top.sv
dv/icache_chk.sv
dv/icache_tb.sv
